// ==== include/endpoint_settings.svh ====
`ifndef ENDPOINT_SETTINGS_SVH
`define ENDPOINT_SETTINGS_SVH

// Sizes
`define NUM_MSGS    4
`define CACHE_WORDS 128
`define CACHE_AW    7
`define SEND_DEPTH  4
`define REQ_DEPTH   4

// Host address map, each cache region spans CACHE_WORDS*4 bytes
`define START_BASE  32'h0000_0000
`define SEND_ADDR   32'h0000_1004
`define TX_BASE     32'h0000_2000
`define RX_BASE     32'h0000_3000
`define REQ_ADDR    32'h0000_3400

`endif

// ==== design/bus_pkg.sv ====
package bus_pkg;

    // Decoded host bus region
    typedef enum logic [2:0] {
        START    = 3'd0,
        SEND     = 3'd1,
        TX_CACHE = 3'd2,
        RX_CACHE = 3'd3,
        REQ      = 3'd4,
        NONE     = 3'd5
    } region_e;

    // Who drives the transmit cache read port
    typedef enum logic {
        BUS    = 1'b0,
        ENGINE = 1'b1
    } owner_e;

endpackage

// ==== design/packet_pkg.sv ====
`include "endpoint_settings.svh"

package packet_pkg;

    typedef logic [$clog2(`NUM_MSGS)-1:0] msg_id_t;

    // Header word layout, destination sits in bits 31..24 and is not used here
    localparam int LEN_LSB  = 0;
    localparam int LEN_W    = 8;
    localparam int META_LSB = 8;
    localparam int META_W   = 7;

    typedef struct packed {
        logic [`CACHE_AW-1:0] start;    // Word address in the receive cache
        logic [LEN_W-1:0]     length;   // Words received, header included
        logic [META_W-1:0]    metadata;
        logic                 crc_error;
        logic                 overflow; // Packet ran past the cache size
    } rx_record_t;

    // Layout of a record as the host reads it at REQ_ADDR
    function automatic logic [31:0] pack_record(rx_record_t rec, logic queue_ovf);
        return {1'b1, rec.overflow | queue_ovf, rec.crc_error, rec.metadata,
                rec.length, rec.start, 7'b0};
    endfunction

endpackage

// ==== design/word_cache.sv ====
`timescale 1ns/1ps

module word_cache #(
    parameter int NUM_WORDS = 128
) (
    input  logic                         clk,
    input  logic                         n_rst,
    input  logic                         wen,
    input  logic [$clog2(NUM_WORDS)-1:0] waddr,
    input  logic [31:0]                  wdata,
    input  logic [3:0]                   strobe,
    input  logic [$clog2(NUM_WORDS)-1:0] raddr,
    output logic [31:0]                  rdata
);
    logic [31:0] mem [NUM_WORDS];

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < NUM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wen) begin
            for (int b = 0; b < 4; b++) begin
                if (strobe[b]) begin
                    mem[waddr][8*b +: 8] <= wdata[8*b +: 8]; // Byte lane write
                end
            end
        end
    end

    assign rdata = mem[raddr];

endmodule

// ==== design/sync_queue.sv ====
`timescale 1ns/1ps

module sync_queue #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     n_rst,
    input  logic     push,
    input  payload_t din,
    input  logic     pop,
    output payload_t dout,
    output logic     full,
    output logic     empty,
    output logic     overflow
);
    localparam int PW = $clog2(DEPTH);

    payload_t        buffer [DEPTH];
    logic [PW-1:0]   rd_ptr, wr_ptr;
    logic [PW:0]     count;
    logic            do_push, do_pop;

    assign empty   = (count == 0);
    assign full    = (count == DEPTH);
    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || do_pop); // A pop frees a slot in the same cycle
    assign dout    = buffer[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            buffer[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (push && !do_push) begin
                overflow <= 1'b1;   // Payload dropped
            end else if (do_pop) begin
                overflow <= 1'b0;
            end
        end
    end

endmodule

// ==== design/bus_decode.sv ====
`timescale 1ns/1ps
`include "endpoint_settings.svh"

module bus_decode (
    input  logic                                clk,
    input  logic                                n_rst,
    input  logic [31:0]                         bus_addr,
    input  logic                                bus_wen,
    input  logic                                bus_ren,
    input  logic [31:0]                         bus_wdata,
    input  logic [3:0]                          bus_strobe,
    output logic [31:0]                         bus_rdata,
    output logic                                bus_error,
    output logic                                bus_stall,
    output logic                                send_push,
    output packet_pkg::msg_id_t                 send_id,
    input  logic                                send_full,
    output logic                                req_pop,
    input  packet_pkg::rx_record_t              req_head,
    input  logic                                req_empty,
    input  logic                                req_overflow,
    output logic                                txc_wen,
    output logic [`CACHE_AW-1:0]                txc_waddr,
    output logic [31:0]                         txc_wdata,
    output logic [3:0]                          txc_strobe,
    output logic [`CACHE_AW-1:0]                txc_raddr,
    input  logic [31:0]                         txc_rdata,
    output logic [`CACHE_AW-1:0]                rxc_raddr,
    input  logic [31:0]                         rxc_rdata,
    input  logic                                tx_rd_req,
    input  logic [`CACHE_AW-1:0]                tx_rd_addr,
    output logic [31:0]                         tx_rd_data,
    output logic                                tx_rd_stall,
    output logic [`NUM_MSGS-1:0][`CACHE_AW-1:0] start_addr,
    input  logic                                rx_busy
);
    bus_pkg::region_e                region;
    bus_pkg::owner_e                 owner;
    logic [`CACHE_AW-1:0]            word_addr;
    logic [$clog2(`NUM_MSGS)-1:0]    start_idx;

    assign word_addr = bus_addr[2 +: `CACHE_AW];
    assign start_idx = bus_addr[2 +: $clog2(`NUM_MSGS)];

    always_comb begin
        if ((bus_addr - `START_BASE) < 4 * `NUM_MSGS)           region = bus_pkg::START;
        else if (bus_addr == `SEND_ADDR)                       region = bus_pkg::SEND;
        else if ((bus_addr - `TX_BASE) < 4 * `CACHE_WORDS)     region = bus_pkg::TX_CACHE;
        else if ((bus_addr - `RX_BASE) < 4 * `CACHE_WORDS)     region = bus_pkg::RX_CACHE;
        else if (bus_addr == `REQ_ADDR)                        region = bus_pkg::REQ;
        else                                                   region = bus_pkg::NONE;
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            start_addr <= '0;
            owner      <= bus_pkg::BUS;
        end else begin
            owner <= tx_rd_req ? bus_pkg::ENGINE : bus_pkg::BUS;
            if (region == bus_pkg::START && bus_wen) begin
                start_addr[start_idx] <= bus_wdata[2 +: `CACHE_AW]; // Word aligned
            end
        end
    end

    // Transmit cache ports
    assign txc_waddr   = word_addr;
    assign txc_wdata   = bus_wdata;
    assign txc_strobe  = bus_strobe;
    assign txc_raddr   = (owner == bus_pkg::ENGINE) ? tx_rd_addr : word_addr;
    assign tx_rd_data  = txc_rdata;
    assign tx_rd_stall = (owner != bus_pkg::ENGINE);
    assign rxc_raddr   = word_addr;
    assign send_id     = bus_wdata[$clog2(`NUM_MSGS)-1:0];

    always_comb begin
        bus_rdata = 32'hBAD1BAD1;
        bus_error = 1'b0;
        bus_stall = 1'b0;
        send_push = 1'b0;
        req_pop   = 1'b0;
        txc_wen   = 1'b0;
        case (region)
            bus_pkg::START: begin
                bus_rdata = {{(30 - `CACHE_AW){1'b0}}, start_addr[start_idx], 2'b00};
            end
            bus_pkg::SEND: begin
                if (bus_wen) begin
                    if (bus_wdata >= `NUM_MSGS) bus_error = 1'b1;
                    else if (send_full)         bus_stall = 1'b1;
                    else                        send_push = 1'b1;
                end
            end
            bus_pkg::TX_CACHE: begin
                if (owner == bus_pkg::ENGINE) begin
                    bus_stall = bus_wen | bus_ren;  // Engine is streaming a packet
                end else begin
                    txc_wen   = bus_wen;
                    bus_rdata = txc_rdata;
                end
            end
            bus_pkg::RX_CACHE: begin
                if (bus_wen)      bus_error = 1'b1;
                else if (rx_busy) bus_stall = bus_ren;
                else              bus_rdata = rxc_rdata;
            end
            bus_pkg::REQ: begin
                if (bus_wen) begin
                    bus_error = 1'b1;
                end else begin
                    bus_rdata = req_empty ? {1'b0, req_overflow, 30'b0}
                                          : packet_pkg::pack_record(req_head, req_overflow);
                    req_pop   = bus_ren & ~req_empty;
                end
            end
            default: bus_error = bus_wen | bus_ren;
        endcase
    end

endmodule

// ==== design/tx_engine.sv ====
`timescale 1ns/1ps
`include "endpoint_settings.svh"

module tx_engine (
    input  logic                                clk,
    input  logic                                n_rst,
    input  logic                                send_empty,
    output logic                                send_pop,
    input  packet_pkg::msg_id_t                 send_head,
    input  logic [`NUM_MSGS-1:0][`CACHE_AW-1:0] start_addr,
    output logic                                tx_rd_req,
    output logic [`CACHE_AW-1:0]                tx_rd_addr,
    input  logic [31:0]                         tx_rd_data,
    input  logic                                tx_rd_stall,
    output logic                                link_tx_valid,
    output logic [31:0]                         link_tx_data,
    output logic                                link_tx_last
);
    typedef enum logic [1:0] { IDLE, HEADER, STREAM } state_e;

    state_e                        state, next_state;
    logic [`CACHE_AW-1:0]          addr, next_addr;
    logic [packet_pkg::LEN_W-1:0]  remaining, next_remaining;
    logic [packet_pkg::LEN_W-1:0]  hdr_len;

    assign hdr_len      = tx_rd_data[packet_pkg::LEN_LSB +: packet_pkg::LEN_W];
    assign tx_rd_addr   = addr;
    assign link_tx_data = tx_rd_data;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state     <= IDLE;
            addr      <= '0;
            remaining <= '0;
        end else begin
            state     <= next_state;
            addr      <= next_addr;
            remaining <= next_remaining;
        end
    end

    always_comb begin
        next_state     = state;
        next_addr      = addr;
        next_remaining = remaining;
        send_pop       = 1'b0;
        tx_rd_req      = 1'b0;
        link_tx_valid  = 1'b0;
        link_tx_last   = 1'b0;
        case (state)
            IDLE: begin
                if (!send_empty) begin
                    send_pop   = 1'b1;
                    next_addr  = start_addr[send_head];
                    next_state = HEADER;
                end
            end
            HEADER: begin
                tx_rd_req = 1'b1;
                if (!tx_rd_stall) begin
                    link_tx_valid = 1'b1;
                    next_addr     = addr + 1'b1;    // Wraps inside the cache
                    if (hdr_len <= 1) begin
                        link_tx_last = 1'b1;        // Zero length goes out as header only
                        next_state   = IDLE;
                    end else begin
                        next_remaining = hdr_len - 1'b1;
                        next_state     = STREAM;
                    end
                end
            end
            STREAM: begin
                tx_rd_req      = 1'b1;
                link_tx_valid  = 1'b1;
                next_addr      = addr + 1'b1;
                next_remaining = remaining - 1'b1;
                if (remaining == 1) begin
                    link_tx_last = 1'b1;
                    next_state   = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

endmodule

// ==== design/rx_engine.sv ====
`timescale 1ns/1ps
`include "endpoint_settings.svh"

module rx_engine (
    input  logic                   clk,
    input  logic                   n_rst,
    input  logic                   link_rx_valid,
    input  logic [31:0]            link_rx_data,
    input  logic                   link_rx_last,
    output logic                   rxc_wen,
    output logic [`CACHE_AW-1:0]   rxc_waddr,
    output logic [31:0]            rxc_wdata,
    output logic                   rx_busy,
    output logic                   req_push,
    output packet_pkg::rx_record_t req_record
);
    logic                              in_pkt;
    logic [`CACHE_AW-1:0]              wptr, pkt_start, start_next;
    logic [8:0]                        count, count_next;
    logic [packet_pkg::META_W-1:0]     meta, meta_next;
    logic [31:0]                       csum, csum_next;

    // The first word of a packet restarts every accumulator
    always_comb begin
        if (in_pkt) begin
            start_next = pkt_start;
            count_next = count + 1'b1;
            meta_next  = meta;
            csum_next  = csum ^ link_rx_data;
        end else begin
            start_next = wptr;
            count_next = 9'd1;
            meta_next  = link_rx_data[packet_pkg::META_LSB +: packet_pkg::META_W];
            csum_next  = link_rx_data;
        end
    end

    assign rxc_wen   = link_rx_valid;
    assign rxc_waddr = wptr;
    assign rxc_wdata = link_rx_data;
    assign rx_busy   = link_rx_valid | in_pkt | req_push;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            in_pkt    <= 1'b0;
            wptr      <= '0;
            pkt_start <= '0;
            count     <= '0;
            meta      <= '0;
            csum      <= '0;
            req_push  <= 1'b0;
        end else begin
            req_push <= link_rx_valid & link_rx_last;
            if (link_rx_valid) begin
                wptr      <= wptr + 1'b1;   // Wraps inside the cache
                in_pkt    <= ~link_rx_last;
                pkt_start <= start_next;
                count     <= count_next;
                meta      <= meta_next;
                csum      <= csum_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (link_rx_valid && link_rx_last) begin
            req_record.start     <= start_next;
            req_record.length    <= count_next[packet_pkg::LEN_W-1:0];
            req_record.metadata  <= meta_next;
            req_record.crc_error <= |csum_next;     // Words must XOR to zero
            req_record.overflow  <= (count_next > `CACHE_WORDS);
        end
    end

endmodule

// ==== design/endpoint.sv ====
`timescale 1ns/1ps
`include "endpoint_settings.svh"

module endpoint (
    input  logic        clk,
    input  logic        n_rst,
    input  logic [31:0] bus_addr,
    input  logic        bus_wen,
    input  logic        bus_ren,
    input  logic [31:0] bus_wdata,
    input  logic [3:0]  bus_strobe,
    output logic [31:0] bus_rdata,
    output logic        bus_error,
    output logic        bus_stall,
    output logic        link_tx_valid,
    output logic [31:0] link_tx_data,
    output logic        link_tx_last,
    input  logic        link_rx_valid,
    input  logic [31:0] link_rx_data,
    input  logic        link_rx_last,
    output logic        packet_recv
);
    logic                                send_push, send_pop, send_full, send_empty;
    packet_pkg::msg_id_t                 send_id, send_head;
    logic                                req_push, req_pop, req_empty, req_overflow;
    packet_pkg::rx_record_t              req_record, req_head;
    logic                                txc_wen, rxc_wen;
    logic [`CACHE_AW-1:0]                txc_waddr, txc_raddr, rxc_waddr, rxc_raddr;
    logic [31:0]                         txc_wdata, txc_rdata, rxc_wdata, rxc_rdata;
    logic [3:0]                          txc_strobe;
    logic                                tx_rd_req, tx_rd_stall, rx_busy;
    logic [`CACHE_AW-1:0]                tx_rd_addr;
    logic [31:0]                         tx_rd_data;
    logic [`NUM_MSGS-1:0][`CACHE_AW-1:0] start_addr;

    assign packet_recv = ~req_empty;

    bus_decode decode (.*);

    tx_engine tx_eng (.*);

    rx_engine rx_eng (.*);

    word_cache #(.NUM_WORDS(`CACHE_WORDS)) tx_cache (
        .clk(clk), .n_rst(n_rst), .wen(txc_wen), .waddr(txc_waddr), .wdata(txc_wdata),
        .strobe(txc_strobe), .raddr(txc_raddr), .rdata(txc_rdata)
    );

    word_cache #(.NUM_WORDS(`CACHE_WORDS)) rx_cache (
        .clk(clk), .n_rst(n_rst), .wen(rxc_wen), .waddr(rxc_waddr), .wdata(rxc_wdata),
        .strobe(4'hF), .raddr(rxc_raddr), .rdata(rxc_rdata)
    );

    sync_queue #(.payload_t(packet_pkg::msg_id_t), .DEPTH(`SEND_DEPTH)) send_queue (
        .clk(clk), .n_rst(n_rst), .push(send_push), .din(send_id), .pop(send_pop),
        .dout(send_head), .full(send_full), .empty(send_empty), .overflow()
    );

    sync_queue #(.payload_t(packet_pkg::rx_record_t), .DEPTH(`REQ_DEPTH)) req_queue (
        .clk(clk), .n_rst(n_rst), .push(req_push), .din(req_record), .pop(req_pop),
        .dout(req_head), .full(), .empty(req_empty), .overflow(req_overflow)
    );

endmodule

// ==== dv/endpoint_tb.sv ====
`timescale 1ns/1ps

module endpoint_tb;
    localparam int TIMEOUT = 200;   // Cycles

    logic        clk;
    logic        n_rst;
    logic [31:0] bus_addr;
    logic        bus_wen;
    logic        bus_ren;
    logic [31:0] bus_wdata;
    logic [3:0]  bus_strobe;
    logic [31:0] bus_rdata;
    logic        bus_error;
    logic        bus_stall;
    logic        link_tx_valid;
    logic [31:0] link_tx_data;
    logic        link_tx_last;
    logic        link_rx_valid;
    logic [31:0] link_rx_data;
    logic        link_rx_last;
    logic        packet_recv;

    int          errors;
    int          checks;
    bit          timed_out;
    bit          tx_open;   // Previous transmit word was not the last one

    endpoint uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        timed_out = 1'b1;
        $display("Timeout at %0t: %s", $time, what);
    endtask

    // Request held until the first edge without stall
    task automatic bus_access(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strobe, output logic [31:0] rdata,
                              output logic err);
        int waited;
        waited = 0;
        @(posedge clk);
        bus_addr   <= addr;
        bus_wen    <= wr;
        bus_ren    <= ~wr;
        bus_wdata  <= data;
        bus_strobe <= strobe;
        @(negedge clk);
        while (bus_stall && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (bus_stall) report_timeout("bus access stayed stalled");
        rdata = bus_rdata;
        err   = bus_error;
        @(posedge clk);
        bus_wen <= 1'b0;
        bus_ren <= 1'b0;
    endtask

    task automatic link_word(input logic [31:0] data, input logic last);
        @(posedge clk);
        link_rx_valid <= 1'b1;
        link_rx_data  <= data;
        link_rx_last  <= last;
        if (last) begin
            @(posedge clk);
            link_rx_valid <= 1'b0;
            link_rx_last  <= 1'b0;
        end
    endtask

    // Words after the first must follow on consecutive cycles
    task automatic tx_word(input logic [31:0] data, input logic last);
        int waited;
        int limit;
        waited = 0;
        limit  = tx_open ? 0 : TIMEOUT;
        @(negedge clk);
        while (!link_tx_valid && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (!link_tx_valid) begin
            report_timeout(tx_open ? "next transmit word did not follow"
                                   : "no transmit word appeared on the link");
        end else begin
            check("link_tx_data", link_tx_data, data);
            check("link_tx_last", 32'(link_tx_last), 32'(last));
        end
        tx_open = !last;
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check("link_tx_valid", 32'(link_tx_valid), 32'd0);
        end
    endtask

    task automatic expect_recv(input logic expected);
        @(posedge clk);
        @(negedge clk);
        check("packet_recv", 32'(packet_recv), 32'(expected));
    endtask

    initial begin
        int          fd;
        int          code;
        int          ch;
        logic [7:0]  op;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] rdata;
        logic        err;
        bit          rx_open;

        errors        = 0;
        checks        = 0;
        timed_out     = 1'b0;
        tx_open       = 1'b0;
        rx_open       = 1'b0;
        n_rst         = 1'b0;
        bus_addr      = '0;
        bus_wen       = 1'b0;
        bus_ren       = 1'b0;
        bus_wdata     = '0;
        bus_strobe    = '0;
        link_rx_valid = 1'b0;
        link_rx_data  = '0;
        link_rx_last  = 1'b0;
        void'($urandom(32'h711e528a));
        repeat (3) @(posedge clk);
        n_rst <= 1'b1;

        fd = $fopen("dv/endpoint_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the case file dv/endpoint_cases.txt");
        end else begin
            while (!timed_out) begin
                code = $fscanf(fd, " %c", op);
                if (code != 1) break;
                if (op == "#") begin    // Comment line
                    ch = $fgetc(fd);
                    while (ch != "\n" && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                    continue;
                end
                if (op != "T" && !rx_open) begin
                    repeat ($urandom % 3) @(posedge clk);
                end
                case (op)
                    "W": begin
                        code = $fscanf(fd, "%h %h", f1, f2);
                        bus_access(1'b1, f1, f2, 4'hF, rdata, err);
                        check("bus_error", 32'(err), 32'd0);
                    end
                    "S": begin
                        code = $fscanf(fd, "%h %h %h", f1, f2, f3);
                        bus_access(1'b1, f1, f2, f3[3:0], rdata, err);
                        check("bus_error", 32'(err), 32'd0);
                    end
                    "R": begin
                        code = $fscanf(fd, "%h %h", f1, f2);
                        bus_access(1'b0, f1, 32'd0, 4'h0, rdata, err);
                        check($sformatf("bus_rdata at %h", f1), rdata, f2);
                    end
                    "E": begin
                        code = $fscanf(fd, "%h %h %h", f1, f2, f3);
                        bus_access(f2[0], f1, f3, 4'hF, rdata, err);
                        check($sformatf("bus_error at %h", f1), 32'(err), 32'd1);
                    end
                    "L": begin
                        code = $fscanf(fd, "%h %h", f1, f2);
                        link_word(f1, f2[0]);
                        rx_open = !f2[0];
                    end
                    "T": begin
                        code = $fscanf(fd, "%h %h", f1, f2);
                        tx_word(f1, f2[0]);
                    end
                    "N": begin
                        code = $fscanf(fd, "%h", f1);
                        expect_quiet(int'(f1));
                    end
                    "P": begin
                        code = $fscanf(fd, "%h", f1);
                        expect_recv(f1[0]);
                    end
                    default: begin
                        errors++;
                        $display("Unknown operation %c in the case file", op);
                    end
                endcase
            end
            $fclose(fd);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+include
design/bus_pkg.sv
design/packet_pkg.sv
design/word_cache.sv
design/sync_queue.sv
design/bus_decode.sv
design/tx_engine.sv
design/rx_engine.sv
design/endpoint.sv
dv/endpoint_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator, run it and check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --top-module endpoint_tb -f flist.f -o endpoint_sim
	./obj_dir/endpoint_sim | tee sim.log
	@grep -q "^PASS: all tests$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/endpoint_cases.txt ====
# Fields in hex. W addr data | S addr data strobe | R addr expected | E addr wr data
# L data last | T data last | N quiet_cycles | P packet_recv
W 2000 12345678
R 2000 12345678
W 2004 aabbccdd
S 2004 11223344 3
S 2004 99000000 8
R 2004 99bb3344
W 0004 0000004b
R 0004 00000048
W 0008 ffffffff
R 0008 000001fc
W 0004 00000040
W 2040 ab000503
W 2044 deadbeef
W 2048 01020304
W 1004 00000001
T ab000503 0
T deadbeef 0
T 01020304 1
W 0008 00000080
W 2080 11000001
W 1004 00000002
T 11000001 1
L 00002a03 0
L 12345678 0
L 12347c7b 1
P 1
R 3400 8a80c000
P 0
R 3000 00002a03
R 3004 12345678
R 3008 12347c7b
L 00001102 0
L ffff0000 1
R 3400 a4408180
P 0
R 3400 00000000
L 00000101 1
L 00000201 1
L 00000301 1
L 00000401 1
L 00000501 1
R 3400 e0404280
R 3400 a0804300
R 3400 a0c04380
R 3400 a1004400
R 3400 00000000
P 0
E 5000 0 00000000
R 5000 bad1bad1
E 3010 1 12345678
R 3010 ffff0000
E 3400 1 00000000
E 1004 1 00000004
N 10
